// File: source/lsu_pkg.sv
// Shared LSU types: words, operation and size enums, memory word union, stage structs
package lsu_pkg;

    typedef logic [31:0] word_t;     // Data or address word
    typedef logic [15:0] halfword_t;
    typedef logic [7:0]  byte_t;

    // Operation kind carried down the pipe
    typedef enum logic [1:0] {
        MEM_OP_NOP   = 2'd0, // No memory access, result is alu_result
        MEM_OP_LOAD  = 2'd1,
        MEM_OP_STORE = 2'd2
    } mem_op_e;

    // Access width
    typedef enum logic [1:0] {
        MEM_SIZE_BYTE     = 2'd0,
        MEM_SIZE_HALFWORD = 2'd1,
        MEM_SIZE_WORD     = 2'd2
    } mem_size_e;

    // One memory word seen as byte lanes or halfword lanes
    typedef union packed {
        byte_t     [3:0] bytes;  // Lane 0 is the lowest address
        halfword_t [1:0] halves;
    } mem_word_u;

    // Operation handed in from execute
    typedef struct packed {
        word_t     pc;
        mem_op_e   mem_op;
        mem_size_e mem_size;
        logic      mem_signed; // Sign-extend sub-word loads
        word_t     alu_result; // Address, or the result of a non-memory op
        word_t     rs2_val;    // Store data
        logic [4:0] rd_idx;
        logic      rd_we;
    } lsu_op_s;

    // Memory-1 to memory-2 transfer, same content as the input
    typedef lsu_op_s m1_to_m2_s;

    // Data-memory request
    typedef struct packed {
        logic        valid;
        logic        we;
        logic [29:0] addr;    // Word address
        logic [3:0]  byte_en;
        mem_word_u   wdata;   // Lane-replicated store data
    } dmem_req_s;

    // Finished operation to writeback
    typedef struct packed {
        word_t      pc;
        logic [4:0] rd_idx;
        logic       rd_we;
        word_t      rd_val;
        mem_op_e    mem_op;
    } lsu_wb_s;

endpackage

// File: source/lsu_pipe_ctrl.sv
// LSU pipeline control: RUN / WAIT_MEM FSM producing stall, timer start and abort
`timescale 1ns/1ps

module lsu_pipe_ctrl #(
    parameter int MEM_LATENCY = 3
) (
    input  logic clk,
    input  logic rst_n,
    input  logic mem_issue,   // Request fired from memory-1 this cycle
    input  logic m2_ready,
    input  logic flush,
    input  logic timer_done,
    output logic timer_start,
    output logic timer_abort,
    output logic stall
);

    typedef enum logic {
        ST_RUN      = 1'b0,
        ST_WAIT_MEM = 1'b1
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   init_q;      // High through reset, drops on first live edge
    logic   rsp_seen;

    // Response window open and memory-2 able to retire
    assign rsp_seen = timer_done && m2_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_RUN;
            init_q  <= 1'b1;
        end else begin
            state_q <= state_d;
            init_q  <= 1'b0;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_RUN: begin
                if (mem_issue && (MEM_LATENCY > 1)) begin
                    state_d = ST_WAIT_MEM; // Single-cycle memory never waits
                end
            end
            ST_WAIT_MEM: begin
                // Follow-on request at release keeps us waiting
                if (rsp_seen && !mem_issue) begin
                    state_d = ST_RUN;
                end
            end
            default: state_d = ST_RUN;
        endcase
        if (flush) begin
            state_d = ST_RUN; // Flush wins over everything
        end
    end

    assign timer_start = mem_issue;
    assign timer_abort = flush;
    // Release combinationally on the response so memory-2 retires that cycle
    assign stall = init_q || ((state_q == ST_WAIT_MEM) && !rsp_seen);

endmodule

// File: source/lsu_wait_timer.sv
// Data-memory latency timer: loadable down-counter with busy flag and done level
`timescale 1ns/1ps

module lsu_wait_timer #(
    parameter int MEM_LATENCY = 3
) (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic abort,
    output logic done    // Held until next start or abort
);

    localparam int CNT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;
    localparam logic [CNT_W-1:0] LOAD_VAL = CNT_W'(MEM_LATENCY - 1);

    logic [CNT_W-1:0] count_q;
    logic             busy_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q <= '0;
            busy_q  <= 1'b0;
            done    <= 1'b0;
        end else if (abort) begin
            busy_q <= 1'b0;
            done   <= 1'b0;
        end else if (start) begin
            count_q <= LOAD_VAL;
            busy_q  <= (MEM_LATENCY > 1);
            done    <= (MEM_LATENCY == 1); // No wait at all for latency 1
        end else if (busy_q) begin
            count_q <= count_q - 1'b1;
            if (count_q == CNT_W'(1)) begin // Last wait cycle
                busy_q <= 1'b0;
                done   <= 1'b1;
            end
        end
    end

endmodule

// File: source/lsu_stage_memory1.sv
// Memory-1 stage: input flops, byte enables, store-data lane replication, dmem request
`timescale 1ns/1ps

module lsu_stage_memory1 (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall,
    input  logic                flush,
    input  logic                in_valid,
    input  lsu_pkg::lsu_op_s    in_op,
    output logic                m1_to_m2_valid,
    output lsu_pkg::m1_to_m2_s  m1_to_m2,
    output lsu_pkg::dmem_req_s  dmem_req,
    output logic                mem_issue
);

    logic               ff_valid;
    lsu_pkg::lsu_op_s   ff_in;
    logic [3:0]         byte_en;
    lsu_pkg::mem_word_u wdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ff_valid <= 1'b0;
        end else if (flush) begin
            ff_valid <= 1'b0;
        end else if (!stall) begin
            ff_valid <= in_valid;
        end
    end

    // Payload holds under stall
    always_ff @(posedge clk) begin
        if (!stall) begin
            ff_in <= in_op;
        end
    end

    // Loads and stores only, never for a flushed op
    assign mem_issue = ff_valid && !stall && !flush && (ff_in.mem_op != lsu_pkg::MEM_OP_NOP);

    // Lane enables and replicated data by access width
    always_comb begin
        case (ff_in.mem_size)
            lsu_pkg::MEM_SIZE_BYTE: begin
                byte_en     = 4'b0001 << ff_in.alu_result[1:0];
                wdata.bytes = {4{ff_in.rs2_val[7:0]}};   // Same byte in every lane
            end
            lsu_pkg::MEM_SIZE_HALFWORD: begin
                byte_en      = 4'b0011 << {ff_in.alu_result[1], 1'b0};
                wdata.halves = {2{ff_in.rs2_val[15:0]}}; // Both halves
            end
            default: begin
                byte_en      = 4'b1111;
                wdata.halves = ff_in.rs2_val;            // Full word as is
            end
        endcase
    end

    always_comb begin
        dmem_req.valid   = mem_issue;
        dmem_req.we      = (ff_in.mem_op == lsu_pkg::MEM_OP_STORE);
        dmem_req.addr    = ff_in.alu_result[31:2]; // Drop byte offset
        dmem_req.byte_en = byte_en;
        dmem_req.wdata   = wdata;
    end

    assign m1_to_m2_valid = ff_valid;
    assign m1_to_m2       = ff_in;

endmodule

// File: source/lsu_stage_memory2.sv
// Memory-2 stage: input flops, response-gated ready, load lane extraction and extension
`timescale 1ns/1ps

module lsu_stage_memory2 (
    input  logic                clk,
    input  logic                rst_n,
    output logic                m2_ready,
    input  logic                m2_flush,
    input  logic                m2_stall,
    input  logic                m1_to_m2_valid,
    input  lsu_pkg::m1_to_m2_s  m1_to_m2,
    input  logic                rsp_ready,
    input  lsu_pkg::word_t      rsp_data,
    output logic                wb_valid,
    output lsu_pkg::lsu_wb_s    wb
);

    logic                ff_valid;
    lsu_pkg::m1_to_m2_s  ff_in;
    lsu_pkg::mem_word_u  rsp_word;
    lsu_pkg::halfword_t  load_half;
    lsu_pkg::byte_t      load_byte;
    logic                ext_half;
    logic                ext_byte;
    lsu_pkg::word_t      load_val;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ff_valid <= 1'b0;
        end else if (m2_flush) begin
            ff_valid <= 1'b0;
        end else if (!m2_stall) begin
            ff_valid <= m1_to_m2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!m2_stall) begin
            ff_in <= m1_to_m2;
        end
    end

    // Nothing to wait for unless a valid memory op sits here
    assign m2_ready = rsp_ready
                   || (ff_in.mem_op == lsu_pkg::MEM_OP_NOP)
                   || !ff_valid;

    // Lane pick from the held response word
    always_comb begin
        rsp_word.halves = rsp_data;
        load_half = rsp_word.halves[ff_in.alu_result[1]];   // Bit 1 picks the half
        load_byte = rsp_word.bytes[ff_in.alu_result[1:0]];  // Bit 0 within that half
        ext_half  = load_half[15] & ff_in.mem_signed;
        ext_byte  = load_byte[7] & ff_in.mem_signed;
        case (ff_in.mem_size)
            lsu_pkg::MEM_SIZE_BYTE:     load_val = {{24{ext_byte}}, load_byte};
            lsu_pkg::MEM_SIZE_HALFWORD: load_val = {{16{ext_half}}, load_half};
            default:                    load_val = rsp_data;
        endcase
    end

    // Low while stalled or flushed
    assign wb_valid = ff_valid && !m2_stall && !m2_flush;

    always_comb begin
        wb.pc     = ff_in.pc;
        wb.rd_idx = ff_in.rd_idx;
        wb.rd_we  = ff_in.rd_we;
        wb.mem_op = ff_in.mem_op;
        // Loads return memory data, everything else the ALU value
        wb.rd_val = (ff_in.mem_op == lsu_pkg::MEM_OP_LOAD) ? load_val : ff_in.alu_result;
    end

endmodule

// File: source/lsu_dmem.sv
// Data memory: word array with per-byte write enables and held read data
`timescale 1ns/1ps

module lsu_dmem #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                clk,
    input  lsu_pkg::dmem_req_s  req,
    input  logic                timer_done,
    output logic                rsp_ready,
    output lsu_pkg::word_t      rsp_data
);

    localparam int AW = $clog2(DMEM_WORDS);

    lsu_pkg::word_t  mem [DMEM_WORDS];
    logic [AW-1:0]   idx;
    lsu_pkg::word_t  rdata_q;

    assign idx = req.addr[AW-1:0]; // Wraps above the array depth

    // Byte-lane writes
    always_ff @(posedge clk) begin
        if (req.valid && req.we) begin
            for (int i = 0; i < 4; i++) begin
                if (req.byte_en[i]) begin
                    mem[idx][i*8 +: 8] <= req.wdata.bytes[i];
                end
            end
        end
    end

    // Read captured at request edge, old data on a store
    always_ff @(posedge clk) begin
        if (req.valid) begin
            rdata_q <= mem[idx];
        end
    end

    assign rsp_data = rdata_q;     // Held until next request
    // Latency window comes from the shared timer
    assign rsp_ready = timer_done;

endmodule

// File: source/lsu_top.sv
// LSU top level: control, latency timer, memory-1, memory-2 and data memory
`timescale 1ns/1ps

module lsu_top #(
    parameter int MEM_LATENCY = 3,
    parameter int DMEM_WORDS  = 256
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  lsu_pkg::lsu_op_s in_op,
    input  logic             flush,
    output logic             in_ready,
    output logic             wb_valid,
    output lsu_pkg::lsu_wb_s wb
);

    logic               stall;
    logic               mem_issue;
    logic               m2_ready;
    logic               timer_start;
    logic               timer_abort;
    logic               timer_done;
    logic               m1_to_m2_valid;
    lsu_pkg::m1_to_m2_s m1_to_m2;
    lsu_pkg::dmem_req_s dmem_req;
    logic               rsp_ready;
    lsu_pkg::word_t     rsp_data;

    assign in_ready = !stall; // Upstream may hand in whenever not stalled

    lsu_pipe_ctrl #(
        .MEM_LATENCY (MEM_LATENCY)
    ) u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_issue   (mem_issue),
        .m2_ready    (m2_ready),
        .flush       (flush),
        .timer_done  (timer_done),
        .timer_start (timer_start),
        .timer_abort (timer_abort),
        .stall       (stall)
    );

    lsu_wait_timer #(
        .MEM_LATENCY (MEM_LATENCY)
    ) u_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .start (timer_start),
        .abort (timer_abort),
        .done  (timer_done)
    );

    lsu_stage_memory1 u_m1 (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .flush          (flush),
        .in_valid       (in_valid),
        .in_op          (in_op),
        .m1_to_m2_valid (m1_to_m2_valid),
        .m1_to_m2       (m1_to_m2),
        .dmem_req       (dmem_req),
        .mem_issue      (mem_issue)
    );

    lsu_stage_memory2 u_m2 (
        .clk            (clk),
        .rst_n          (rst_n),
        .m2_ready       (m2_ready),
        .m2_flush       (flush),
        .m2_stall       (stall),
        .m1_to_m2_valid (m1_to_m2_valid),
        .m1_to_m2       (m1_to_m2),
        .rsp_ready      (rsp_ready),
        .rsp_data       (rsp_data),
        .wb_valid       (wb_valid),
        .wb             (wb)
    );

    lsu_dmem #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_dmem (
        .clk        (clk),
        .req        (dmem_req),
        .timer_done (timer_done),
        .rsp_ready  (rsp_ready),
        .rsp_data   (rsp_data)
    );

endmodule

// File: tests/tb_lsu.sv
// LSU testbench: clock and reset, byte reference memory, writeback monitor, directed tests
`timescale 1ns/1ps

module tb_lsu;

    localparam int MEM_LATENCY = 3;
    localparam int MAX_CYCLES  = 2000;          // About 270 ops at 3 cycles each plus drains
    localparam int RAND_SEED   = 32'h0ea98be2;

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    lsu_pkg::lsu_op_s in_op;
    logic             flush;
    logic             in_ready;
    logic             wb_valid;
    lsu_pkg::lsu_wb_s wb;

    lsu_pkg::byte_t   ref_mem [1024];   // Byte image of the 256-word memory
    lsu_pkg::lsu_wb_s exp_q [$];        // Expected writebacks with the oldest first
    int               acc_q [$];        // Acceptance cycle per entry
    int               cycle;
    int               last_acc;
    int               last_wb;
    string            cur_test;
    lsu_pkg::word_t   pc_next;

    lsu_top #(
        .MEM_LATENCY (MEM_LATENCY),
        .DMEM_WORDS  (256)
    ) u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_op    (in_op),
        .flush    (flush),
        .in_ready (in_ready),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at first error");
    endtask

    // Little-endian lanes extended by the sign flag
    function automatic lsu_pkg::word_t read_ref(input lsu_pkg::word_t addr,
                                                input lsu_pkg::mem_size_e size,
                                                input logic sgn);
        int             a;
        lsu_pkg::word_t v;
        case (size)
            lsu_pkg::MEM_SIZE_BYTE: begin
                a = int'(addr[9:0]);
                v = {{24{sgn & ref_mem[a][7]}}, ref_mem[a]};
            end
            lsu_pkg::MEM_SIZE_HALFWORD: begin
                a = int'({addr[9:1], 1'b0});
                v = {{16{sgn & ref_mem[a+1][7]}}, ref_mem[a+1], ref_mem[a]};
            end
            default: begin
                a = int'({addr[9:2], 2'b00});
                v = {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
            end
        endcase
        return v;
    endfunction

    function automatic void write_ref(input lsu_pkg::word_t addr,
                                      input lsu_pkg::mem_size_e size,
                                      input lsu_pkg::word_t data);
        int a;
        a = int'(addr[9:0]);
        if (size == lsu_pkg::MEM_SIZE_BYTE) begin
            ref_mem[a] = data[7:0];
        end else if (size == lsu_pkg::MEM_SIZE_HALFWORD) begin
            a = int'({addr[9:1], 1'b0});
            ref_mem[a]   = data[7:0];
            ref_mem[a+1] = data[15:8];
        end else begin
            a = int'({addr[9:2], 2'b00});
            for (int i = 0; i < 4; i++) begin
                ref_mem[a+i] = data[i*8 +: 8];
            end
        end
    endfunction

    // Expected writeback applied to the model in acceptance order
    function automatic lsu_pkg::lsu_wb_s predict_wb(input lsu_pkg::lsu_op_s op);
        lsu_pkg::lsu_wb_s e;
        e.pc     = op.pc;
        e.rd_idx = op.rd_idx;
        e.rd_we  = op.rd_we;
        e.mem_op = op.mem_op;
        e.rd_val = op.alu_result; // Stores and non-memory ops
        if (op.mem_op == lsu_pkg::MEM_OP_LOAD) begin
            e.rd_val = read_ref(op.alu_result, op.mem_size, op.mem_signed);
        end else if (op.mem_op == lsu_pkg::MEM_OP_STORE) begin
            write_ref(op.alu_result, op.mem_size, op.rs2_val);
        end
        return e;
    endfunction

    function automatic lsu_pkg::lsu_op_s build_op(input lsu_pkg::mem_op_e kind,
                                                  input lsu_pkg::mem_size_e size,
                                                  input logic sgn,
                                                  input lsu_pkg::word_t addr,
                                                  input lsu_pkg::word_t data);
        lsu_pkg::lsu_op_s op;
        op.pc         = pc_next;
        op.mem_op     = kind;
        op.mem_size   = size;
        op.mem_signed = sgn;
        op.alu_result = addr;
        op.rs2_val    = data;
        op.rd_idx     = pc_next[6:2];
        op.rd_we      = (kind != lsu_pkg::MEM_OP_STORE);
        pc_next       = pc_next + 32'd4;
        return op;
    endfunction

    // Checks sampled at the rising edge with inputs settled since the falling edge
    always @(posedge clk) begin
        if (rst_n) begin
            assert (cycle < MAX_CYCLES) else begin
                $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
                fail_run();
            end
            if (flush) begin
                assert (!wb_valid) else begin
                    $display("error: %s: expected wb_valid 0, actual 1", cur_test);
                    fail_run();
                end
                exp_q.delete(); // Both stages dropped
                acc_q.delete();
            end else begin
                // Issued memory op not yet answered must hold off upstream
                if (exp_q.size() != 0 && !wb_valid && cycle - acc_q[0] >= 2
                    && exp_q[0].mem_op != lsu_pkg::MEM_OP_NOP) begin
                    assert (!in_ready) else begin
                        $display("%s: in_ready high during a memory access", cur_test);
                        fail_run();
                    end
                end
                if (wb_valid) begin
                    assert (exp_q.size() != 0) else begin
                        $display("%s: wb_valid with no operation in flight", cur_test);
                        fail_run();
                    end
                    assert (wb == exp_q[0]) else begin
                        $display("error: %s: expected %h, actual %h", cur_test, exp_q[0], wb);
                        fail_run();
                    end
                    void'(exp_q.pop_front());
                    void'(acc_q.pop_front());
                    last_wb = cycle;
                end
                if (in_valid && in_ready) begin
                    exp_q.push_back(predict_wb(in_op));
                    acc_q.push_back(cycle);
                    last_acc = cycle;
                end
            end
        end
        cycle = cycle + 1;
    end

    task automatic send_op(input lsu_pkg::lsu_op_s op);
        @(negedge clk);
        while (!in_ready) begin
            in_valid = 1'b0; // Stall holds off the next op
            @(negedge clk);
        end
        in_valid = 1'b1;
        in_op    = op;
    endtask

    // One-cycle flush with the input idle
    task automatic pulse_flush();
        @(negedge clk);
        in_valid = 1'b0;
        flush    = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    task automatic wait_drain();
        @(negedge clk);
        in_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic check_latency(input int expected);
        assert (last_wb - last_acc == expected) else begin
            $display("error: %s: expected latency %0d, actual %0d", cur_test, expected,
                     last_wb - last_acc);
            fail_run();
        end
    endtask

    task automatic test_nop_latency();
        cur_test = "test_nop_latency";
        send_op(build_op(lsu_pkg::MEM_OP_NOP, lsu_pkg::MEM_SIZE_WORD, 1'b0, 32'hCAFE_0123, '0));
        wait_drain();
        check_latency(2);
    endtask

    task automatic test_word_store_load();
        cur_test = "test_word_store_load";
        for (int i = 0; i < 6; i++) begin
            send_op(build_op(lsu_pkg::MEM_OP_STORE, lsu_pkg::MEM_SIZE_WORD, 1'b0,
                             32'h100 + i * 4, $urandom));
        end
        for (int i = 5; i >= 0; i--) begin
            send_op(build_op(lsu_pkg::MEM_OP_LOAD, lsu_pkg::MEM_SIZE_WORD, 1'b0,
                             32'h100 + i * 4, '0));
        end
        wait_drain();
        // Lone load on an idle pipe sees the full latency
        send_op(build_op(lsu_pkg::MEM_OP_LOAD, lsu_pkg::MEM_SIZE_WORD, 1'b0, 32'h104, '0));
        wait_drain();
        check_latency(2 + MEM_LATENCY - 1);
    endtask

    task automatic test_subword_extend();
        cur_test = "test_subword_extend";
        send_op(build_op(lsu_pkg::MEM_OP_STORE, lsu_pkg::MEM_SIZE_WORD, 1'b0,
                         32'h118, 32'h80F1_7F02)); // Lanes with and without sign bit
        for (int s = 0; s < 2; s++) begin
            for (int off = 0; off < 4; off++) begin
                send_op(build_op(lsu_pkg::MEM_OP_LOAD, lsu_pkg::MEM_SIZE_BYTE, 1'(s),
                                 32'h118 + off, '0));
            end
            for (int off = 0; off < 4; off += 2) begin
                send_op(build_op(lsu_pkg::MEM_OP_LOAD, lsu_pkg::MEM_SIZE_HALFWORD, 1'(s),
                                 32'h118 + off, '0));
            end
        end
        wait_drain();
    endtask

    task automatic test_byte_lane_write();
        cur_test = "test_byte_lane_write";
        send_op(build_op(lsu_pkg::MEM_OP_STORE, lsu_pkg::MEM_SIZE_WORD, 1'b0,
                         32'h120, 32'h1122_3344));
        send_op(build_op(lsu_pkg::MEM_OP_STORE, lsu_pkg::MEM_SIZE_BYTE, 1'b0, 32'h121, 32'hAB));
        send_op(build_op(lsu_pkg::MEM_OP_STORE, lsu_pkg::MEM_SIZE_HALFWORD, 1'b0,
                         32'h122, 32'hCDEF));
        send_op(build_op(lsu_pkg::MEM_OP_LOAD, lsu_pkg::MEM_SIZE_WORD, 1'b0, 32'h120, '0));
        send_op(build_op(lsu_pkg::MEM_OP_STORE, lsu_pkg::MEM_SIZE_WORD, 1'b0,
                         32'h124, 32'h5566_7788));
        send_op(build_op(lsu_pkg::MEM_OP_STORE, lsu_pkg::MEM_SIZE_BYTE, 1'b0, 32'h127, 32'h99));
        send_op(build_op(lsu_pkg::MEM_OP_STORE, lsu_pkg::MEM_SIZE_HALFWORD, 1'b0,
                         32'h124, 32'h1234));
        send_op(build_op(lsu_pkg::MEM_OP_LOAD, lsu_pkg::MEM_SIZE_WORD, 1'b0, 32'h124, '0));
        wait_drain();
    endtask

    task automatic test_random_stream();
        lsu_pkg::mem_op_e   kind;
        lsu_pkg::mem_size_e size;
        lsu_pkg::word_t     addr;
        cur_test = "test_random_stream";
        for (int w = 0; w < 16; w++) begin
            addr = w * 4;
            send_op(build_op(lsu_pkg::MEM_OP_STORE, lsu_pkg::MEM_SIZE_WORD, 1'b0, addr,
                             (addr * 32'h9E37_79B1) ^ 32'hA5C3_0F96)); // Whole-address fill
        end
        for (int n = 0; n < 200; n++) begin
            kind = lsu_pkg::mem_op_e'(2'($urandom_range(2, 0)));
            size = lsu_pkg::mem_size_e'(2'($urandom_range(2, 0)));
            addr = $urandom_range(63, 0); // Inside the filled region
            if (size == lsu_pkg::MEM_SIZE_HALFWORD) begin
                addr[0] = 1'b0;
            end else if (size == lsu_pkg::MEM_SIZE_WORD) begin
                addr[1:0] = 2'b00;
            end
            if (kind == lsu_pkg::MEM_OP_NOP) begin
                addr = $urandom;
            end
            send_op(build_op(kind, size, 1'($urandom_range(1, 0)), addr, $urandom));
        end
        wait_drain();
    endtask

    task automatic test_flush();
        cur_test = "test_flush";
        // Store waiting in memory-2 and no-op in memory-1
        send_op(build_op(lsu_pkg::MEM_OP_STORE, lsu_pkg::MEM_SIZE_WORD, 1'b0,
                         32'h140, 32'h5EED_F00D));
        send_op(build_op(lsu_pkg::MEM_OP_NOP, lsu_pkg::MEM_SIZE_WORD, 1'b0, 32'h0BAD, '0));
        pulse_flush();
        // No-op about to retire from memory-2 and load not yet issued in memory-1
        send_op(build_op(lsu_pkg::MEM_OP_NOP, lsu_pkg::MEM_SIZE_WORD, 1'b0, 32'h0F0F, '0));
        send_op(build_op(lsu_pkg::MEM_OP_LOAD, lsu_pkg::MEM_SIZE_WORD, 1'b0, 32'h140, '0));
        pulse_flush();
        send_op(build_op(lsu_pkg::MEM_OP_LOAD, lsu_pkg::MEM_SIZE_WORD, 1'b0, 32'h140, '0));
        send_op(build_op(lsu_pkg::MEM_OP_NOP, lsu_pkg::MEM_SIZE_WORD, 1'b0, 32'h600D, '0));
        wait_drain();
    endtask

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_op    = '0;
        flush    = 1'b0;
        cycle    = 0;
        last_acc = 0;
        last_wb  = 0;
        pc_next  = 32'h0000_1000;
        cur_test = "reset";
        void'($urandom(RAND_SEED));
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        test_nop_latency();
        test_word_store_load();
        test_subword_extend();
        test_byte_lane_write();
        test_random_stream();
        test_flush();
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: verilog.f
source/lsu_pkg.sv
source/lsu_pipe_ctrl.sv
source/lsu_wait_timer.sv
source/lsu_stage_memory1.sv
source/lsu_stage_memory2.sv
source/lsu_dmem.sv
source/lsu_top.sv
tests/tb_lsu.sv

// File: run_sim.sh
#!/bin/sh
# Build the LSU testbench with Verilator, run it, and check the log for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -f verilog.f --top-module tb_lsu \
    -Mdir obj_dir -o sim_lsu > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_lsu > sim.log 2>&1
cat sim.log

grep -q "^PASS: all tests$" sim.log && exit 0 || exit 1
